// File: design/filterSettings.svh
`ifndef FILTER_SETTINGS_SVH
`define FILTER_SETTINGS_SVH

// image held on chip
`define IMG_W 16
`define IMG_H 16

// grayscale pixel width
`define PIX_BITS 8

// reduced raster in clocks per line and lines per frame
`define H_TOTAL 24
`define V_TOTAL 20
`define H_SYNC 2
`define V_SYNC 1

// signed convolution sum
`define ACC_BITS 16

// start to done in clocks
// three beats per pixel plus memory, execute and result stages
`define PASS_LATENCY (3 * `IMG_W * `IMG_H + 3)

`endif

// File: design/filterPkg.sv
`include "filterSettings.svh"

package filterPkg;
	typedef logic [`PIX_BITS-1:0] pixelT;
	typedef logic [$clog2(`IMG_W * `IMG_H)-1:0] pixAddrT;
	typedef logic [3:0] coordT;
	typedef logic signed [`ACC_BITS-1:0] accT;

	typedef enum logic [1:0] {
		kernIdentity = 2'd0,
		kernBlur = 2'd1,
		kernSharpen = 2'd2,
		kernEdge = 2'd3
	} kernelT;

	typedef enum logic {
		stIdle,
		stSweep
	} sweepStateT;

	// rows indexed 0 above, 1 same, 2 below
	typedef struct packed {
		logic valid;
		pixAddrT [2:0] rowAddr;
		logic [1:0] beat;
		pixAddrT pixAddr;
		kernelT kernel;
	} rowReadT;

	typedef struct packed {
		logic valid;
		pixelT [2:0] pix;
		logic [1:0] beat;
		pixAddrT pixAddr;
		kernelT kernel;
	} tapBeatT;

	typedef struct packed {
		logic valid;
		accT sum;
		pixAddrT pixAddr;
		kernelT kernel;
	} sumT;

	typedef struct packed {
		logic valid;
		pixAddrT pixAddr;
		pixelT pixel;
	} resultWriteT;
endpackage

// File: design/filterDecode.sv
`include "filterSettings.svh"

module filterDecode (
	input logic CLK,
	input logic reset,
	input logic kernel1,
	input logic kernel2,
	input logic kernel3,
	input logic identity,
	input logic start,
	output logic busy,
	output filterPkg::rowReadT readReq,
	input filterPkg::pixelT [2:0] readPixels,
	output filterPkg::tapBeatT tapBeat
);
	import filterPkg::*;

	localparam coordT lastX = coordT'(`IMG_W - 1);
	localparam coordT lastY = coordT'(`IMG_H - 1);

	kernelT buttonKernel;
	kernelT nextKernel;
	kernelT passKernel;
	sweepStateT state;
	coordT x;
	coordT y;
	coordT col;
	coordT rowUp;
	coordT rowDown;
	logic [1:0] beat;
	logic lastBeat;
	logic tapValid;
	logic [1:0] tapBeatNum;
	pixAddrT tapAddr;
	kernelT tapKernel;

	function automatic pixAddrT toAddr(coordT cx, coordT cy);
		return pixAddrT'(cy * `IMG_W + cx);
	endfunction

	// kernel1 wins over kernel2, kernel2 over kernel3, kernel3 over identity
	always_comb begin
		nextKernel = buttonKernel;
		if (kernel1) begin
			nextKernel = kernBlur;
		end else if (kernel2) begin
			nextKernel = kernSharpen;
		end else if (kernel3) begin
			nextKernel = kernEdge;
		end else if (identity) begin
			nextKernel = kernIdentity;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			buttonKernel <= kernIdentity;
		end else begin
			buttonKernel <= nextKernel;
		end
	end

	assign lastBeat = (beat == 2'd2) && (x == lastX) && (y == lastY);
	assign busy = (state == stSweep);

	// raster sweep, three column beats per pixel
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= stIdle;
			x <= '0;
			y <= '0;
			beat <= '0;
			passKernel <= kernIdentity;
		end else begin
			case (state)
				stIdle: begin
					// kernel frozen here for the whole pass
					if (start) begin
						state <= stSweep;
						x <= '0;
						y <= '0;
						beat <= '0;
						passKernel <= nextKernel;
					end
				end
				stSweep: begin
					if (beat == 2'd2) begin
						beat <= '0;
						if (x == lastX) begin
							x <= '0;
							y <= (y == lastY) ? '0 : y + 1'b1;
						end else begin
							x <= x + 1'b1;
						end
						if (lastBeat) begin
							state <= stIdle;
						end
					end else begin
						beat <= beat + 2'd1;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// neighbours past the border reuse the edge coordinate
	always_comb begin
		case (beat)
			2'd0: col = (x == '0) ? x : x - 1'b1;
			2'd2: col = (x == lastX) ? x : x + 1'b1;
			default: col = x;
		endcase
		rowUp = (y == '0) ? y : y - 1'b1;
		rowDown = (y == lastY) ? y : y + 1'b1;
	end

	always_comb begin
		readReq.valid = (state == stSweep);
		readReq.rowAddr[0] = toAddr(col, rowUp);
		readReq.rowAddr[1] = toAddr(col, y);
		readReq.rowAddr[2] = toAddr(col, rowDown);
		readReq.beat = beat;
		readReq.pixAddr = toAddr(x, y);
		readReq.kernel = passKernel;
	end

	// request fields follow the one-cycle memory read
	always_ff @(posedge CLK) begin
		if (reset) begin
			tapValid <= 1'b0;
		end else begin
			tapValid <= readReq.valid;
		end
		tapBeatNum <= readReq.beat;
		tapAddr <= readReq.pixAddr;
		tapKernel <= readReq.kernel;
	end

	always_comb begin
		tapBeat.valid = tapValid;
		tapBeat.pix = readPixels;
		tapBeat.beat = tapBeatNum;
		tapBeat.pixAddr = tapAddr;
		tapBeat.kernel = tapKernel;
	end
endmodule

// File: design/imageMemory.sv
`include "filterSettings.svh"

module imageMemory (
	input logic CLK,
	input logic loadValid,
	input filterPkg::pixAddrT loadAddr,
	input filterPkg::pixelT loadPixel,
	input filterPkg::rowReadT readReq,
	output filterPkg::pixelT [2:0] readPixels,
	input filterPkg::resultWriteT resultWrite,
	input filterPkg::pixAddrT scanAddr,
	output filterPkg::pixelT scanPixel
);
	import filterPkg::*;

	localparam int depth = `IMG_W * `IMG_H;

	// source image, written only by the load strobe
	pixelT srcImg [depth];
	// filtered image shown by scan-out
	pixelT resImg [depth];

	always_ff @(posedge CLK) begin
		if (loadValid) begin
			srcImg[loadAddr] <= loadPixel;
		end
	end

	// three rows of one column per beat
	always_ff @(posedge CLK) begin
		if (readReq.valid) begin
			for (int i = 0; i < 3; i++) begin
				readPixels[i] <= srcImg[readReq.rowAddr[i]];
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (resultWrite.valid) begin
			resImg[resultWrite.pixAddr] <= resultWrite.pixel;
		end
	end

	// free-running read for the raster
	always_ff @(posedge CLK) begin
		scanPixel <= resImg[scanAddr];
	end
endmodule

// File: design/filterExecute.sv
module filterExecute (
	input logic CLK,
	input logic reset,
	input filterPkg::tapBeatT tapBeat,
	output filterPkg::sumT sum
);
	import filterPkg::*;

	// weights by kernel, column beat and row
	localparam logic signed [4:0] coefTable [4][3][3] = '{
		'{'{0, 0, 0}, '{0, 1, 0}, '{0, 0, 0}},
		'{'{1, 2, 1}, '{2, 4, 2}, '{1, 2, 1}},
		'{'{0, -1, 0}, '{-1, 5, -1}, '{0, -1, 0}},
		'{'{-1, -1, -1}, '{-1, 8, -1}, '{-1, -1, -1}}
	};

	accT acc;
	accT beatSum;
	logic lastBeat;

	// one weighted column of the window
	always_comb begin
		beatSum = '0;
		for (int rowIdx = 0; rowIdx < 3; rowIdx++) begin
			beatSum += accT'(coefTable[tapBeat.kernel][tapBeat.beat][rowIdx])
				* accT'({1'b0, tapBeat.pix[rowIdx]});
		end
	end

	assign lastBeat = tapBeat.valid && (tapBeat.beat == 2'd2);

	// beat 0 restarts the window
	always_ff @(posedge CLK) begin
		if (tapBeat.valid) begin
			if (tapBeat.beat == 2'd0) begin
				acc <= beatSum;
			end else begin
				acc <= acc + beatSum;
			end
		end
	end

	// finished sum leaves on the cycle after beat 2
	always_ff @(posedge CLK) begin
		if (lastBeat) begin
			sum.sum <= acc + beatSum;
			sum.pixAddr <= tapBeat.pixAddr;
			sum.kernel <= tapBeat.kernel;
		end
		if (reset) begin
			sum.valid <= 1'b0;
		end else begin
			sum.valid <= lastBeat;
		end
	end
endmodule

// File: design/filterResult.sv
`include "filterSettings.svh"

module filterResult (
	input logic CLK,
	input logic reset,
	input filterPkg::sumT sum,
	output filterPkg::resultWriteT resultWrite,
	output logic done
);
	import filterPkg::*;

	localparam accT pixMax = accT'((1 << `PIX_BITS) - 1);
	localparam pixAddrT lastAddr = pixAddrT'(`IMG_W * `IMG_H - 1);

	logic [2:0] shiftAmt;
	accT shifted;
	pixelT clamped;

	// divisor per kernel, only blur normalises
	always_comb begin
		case (sum.kernel)
			kernBlur: shiftAmt = 3'd4;
			default: shiftAmt = 3'd0;
		endcase
	end

	// arithmetic shift keeps negative sums negative
	always_comb begin
		shifted = sum.sum >>> shiftAmt;
		if (shifted < 0) begin
			clamped = '0;
		end else if (shifted > pixMax) begin
			clamped = '1;
		end else begin
			clamped = pixelT'(shifted);
		end
	end

	always_ff @(posedge CLK) begin
		resultWrite.pixAddr <= sum.pixAddr;
		resultWrite.pixel <= clamped;
		if (reset) begin
			resultWrite.valid <= 1'b0;
			done <= 1'b0;
		end else begin
			resultWrite.valid <= sum.valid;
			// same cycle as the last pixel write
			done <= sum.valid && (sum.pixAddr == lastAddr);
		end
	end
endmodule

// File: design/scanOut.sv
`include "filterSettings.svh"

module scanOut (
	input logic CLK,
	input logic reset,
	output filterPkg::pixAddrT scanAddr,
	input filterPkg::pixelT scanPixel,
	output logic hsync,
	output logic vsync,
	output logic videoActive,
	output filterPkg::pixelT r,
	output filterPkg::pixelT g,
	output filterPkg::pixelT b
);
	import filterPkg::*;

	localparam int hBits = $clog2(`H_TOTAL);
	localparam int vBits = $clog2(`V_TOTAL);

	logic [hBits-1:0] hCount;
	logic [vBits-1:0] vCount;
	logic active;
	logic hsyncRaw;
	logic vsyncRaw;
	pixelT gray;

	// raster position
	always_ff @(posedge CLK) begin
		if (reset) begin
			hCount <= '0;
			vCount <= '0;
		end else if (hCount == hBits'(`H_TOTAL - 1)) begin
			hCount <= '0;
			vCount <= (vCount == vBits'(`V_TOTAL - 1)) ? '0 : vCount + 1'b1;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	// image sits top left, sync pulses at the end of line and frame
	assign active = (hCount < hBits'(`IMG_W)) && (vCount < vBits'(`IMG_H));
	assign hsyncRaw = !(hCount >= hBits'(`H_TOTAL - `H_SYNC));
	assign vsyncRaw = !(vCount >= vBits'(`V_TOTAL - `V_SYNC));
	assign scanAddr = active ? pixAddrT'(vCount * `IMG_W + hCount) : '0;

	// one cycle late to line up with the memory read
	always_ff @(posedge CLK) begin
		if (reset) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			videoActive <= 1'b0;
		end else begin
			hsync <= hsyncRaw;
			vsync <= vsyncRaw;
			videoActive <= active;
		end
	end

	// black outside the image
	assign gray = videoActive ? scanPixel : '0;
	assign r = gray;
	assign g = gray;
	assign b = gray;
endmodule

// File: design/filterTop.sv
module filterTop (
	input logic CLK,
	input logic reset,
	input logic kernel1,
	input logic kernel2,
	input logic kernel3,
	input logic identity,
	input logic start,
	input logic loadValid,
	input filterPkg::pixAddrT loadAddr,
	input filterPkg::pixelT loadPixel,
	output logic busy,
	output logic done,
	output logic hsync,
	output logic vsync,
	output logic videoActive,
	output filterPkg::pixelT r,
	output filterPkg::pixelT g,
	output filterPkg::pixelT b
);
	import filterPkg::*;

	rowReadT readReq;
	pixelT [2:0] readPixels;
	tapBeatT tapBeat;
	sumT sum;
	resultWriteT resultWrite;
	pixAddrT scanAddr;
	pixelT scanPixel;

	// decode stage with kernel buttons and sweep
	filterDecode decode (
		.CLK(CLK), .reset(reset),
		.kernel1(kernel1), .kernel2(kernel2), .kernel3(kernel3), .identity(identity),
		.start(start), .busy(busy),
		.readReq(readReq), .readPixels(readPixels), .tapBeat(tapBeat)
	);

	imageMemory memory (
		.CLK(CLK),
		.loadValid(loadValid), .loadAddr(loadAddr), .loadPixel(loadPixel),
		.readReq(readReq), .readPixels(readPixels),
		.resultWrite(resultWrite),
		.scanAddr(scanAddr), .scanPixel(scanPixel)
	);

	filterExecute execute (
		.CLK(CLK), .reset(reset),
		.tapBeat(tapBeat), .sum(sum)
	);

	filterResult result (
		.CLK(CLK), .reset(reset),
		.sum(sum), .resultWrite(resultWrite), .done(done)
	);

	// video side runs free from reset
	scanOut scan (
		.CLK(CLK), .reset(reset),
		.scanAddr(scanAddr), .scanPixel(scanPixel),
		.hsync(hsync), .vsync(vsync), .videoActive(videoActive),
		.r(r), .g(g), .b(b)
	);
endmodule

// File: sim/filterTb.sv
`include "filterSettings.svh"

module filterTb;
	import filterPkg::*;

	localparam int numPix = `IMG_W * `IMG_H;
	localparam int waitLimit = 4 * `PASS_LATENCY;
	localparam int frameLimit = 3 * `H_TOTAL * `V_TOTAL;

	logic CLK = 1'b0;
	logic reset;
	logic kernel1;
	logic kernel2;
	logic kernel3;
	logic identity;
	logic start;
	logic loadValid;
	pixAddrT loadAddr;
	pixelT loadPixel;
	logic busy;
	logic done;
	logic hsync;
	logic vsync;
	logic videoActive;
	pixelT r;
	pixelT g;
	pixelT b;

	// own copy of the source image and the captured frame per colour
	int srcModel [numPix];
	int shownR [numPix];
	int shownG [numPix];
	int shownB [numPix];
	int errorCount = 0;
	int checkCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int errorsAtStart = 0;

	filterTop dut (.*);

	always #10 CLK = ~CLK;

	task automatic check(string name, int got, int expected);
		checkCount++;
		if (got != expected) begin
			errorCount++;
			$display("error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
		end
	endtask

	task automatic failNote(string what);
		errorCount++;
		$display("at %0t: %s", $time, what);
	endtask

	task automatic endTest(string name);
		testsRun++;
		if (errorCount > errorsAtStart) begin
			testsFailed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: passed", name);
		end
		errorsAtStart = errorCount;
	endtask

	// drive point just after the rising edge
	task automatic nextCycle();
		@(posedge CLK);
		#2;
	endtask

	// window weight for offsets dy and dx in -1..1
	function automatic int weight(kernelT kern, int dy, int dx);
		case (kern)
			kernBlur: return (dx == 0 ? 2 : 1) * (dy == 0 ? 2 : 1);
			kernSharpen: return (dx == 0 && dy == 0) ? 5 : ((dx == 0 || dy == 0) ? -1 : 0);
			kernEdge: return (dx == 0 && dy == 0) ? 8 : -1;
			default: return (dx == 0 && dy == 0) ? 1 : 0;
		endcase
	endfunction

	function automatic int nearest(int c, int last);
		return (c < 0) ? 0 : ((c > last) ? last : c);
	endfunction

	function automatic int expectedPixel(kernelT kern, int x, int y);
		int acc;
		int addr;
		acc = 0;
		for (int dy = -1; dy <= 1; dy++) begin
			for (int dx = -1; dx <= 1; dx++) begin
				addr = nearest(y + dy, `IMG_H - 1) * `IMG_W + nearest(x + dx, `IMG_W - 1);
				acc += weight(kern, dy, dx) * srcModel[addr];
			end
		end
		// blur divides by 16
		if (kern == kernBlur) begin
			acc = acc >>> 4;
		end
		return (acc < 0) ? 0 : ((acc > 255) ? 255 : acc);
	endfunction

	// extremes seeds black and white pixels for the clamp tests
	task automatic loadImage(bit extremes);
		int unsigned pick;
		for (int a = 0; a < numPix; a++) begin
			pick = $urandom % 8;
			if (extremes && (pick == 0 || a == 0)) begin
				srcModel[a] = 0;
			end else if (extremes && (pick == 1 || a == numPix - 1)) begin
				srcModel[a] = 255;
			end else begin
				srcModel[a] = int'($urandom % 256);
			end
			nextCycle();
			loadValid = 1'b1;
			loadAddr = pixAddrT'(a);
			loadPixel = pixelT'(srcModel[a]);
		end
		nextCycle();
		loadValid = 1'b0;
	endtask

	task automatic pulseButtons(logic k1, logic k2, logic k3, logic id);
		nextCycle();
		kernel1 = k1;
		kernel2 = k2;
		kernel3 = k3;
		identity = id;
		nextCycle();
		kernel1 = 1'b0;
		kernel2 = 1'b0;
		kernel3 = 1'b0;
		identity = 1'b0;
	endtask

	// disturb presses kernel3 and a second start mid-pass
	task automatic runPass(bit disturb);
		int cycles;
		int doneCount;
		cycles = 0;
		doneCount = 0;
		nextCycle();
		start = 1'b1;
		while (cycles < waitLimit && doneCount == 0) begin
			nextCycle();
			cycles++;
			start = 1'b0;
			kernel3 = 1'b0;
			if (disturb && cycles == 50) begin
				check("busy", busy, 1);
				kernel3 = 1'b1;
				start = 1'b1;
			end
			if (done) begin
				doneCount++;
			end
		end
		if (doneCount == 0) begin
			failNote("done never came within the timeout");
		end else begin
			check("cycles from start to done", cycles, `PASS_LATENCY);
		end
		// done is a single pulse and no pass follows
		repeat (40) begin
			nextCycle();
			if (done) begin
				doneCount++;
			end
		end
		check("done pulses", doneCount, 1);
		check("busy", busy, 0);
	endtask

	task automatic captureFrame();
		int count;
		int waited;
		logic lastVsync;
		logic fell;
		count = 0;
		waited = 0;
		fell = 1'b0;
		lastVsync = vsync;
		while (waited < frameLimit && !fell) begin
			@(negedge CLK);
			waited++;
			fell = lastVsync && !vsync;
			lastVsync = vsync;
		end
		while (fell && count < numPix && waited < frameLimit) begin
			@(negedge CLK);
			waited++;
			if (videoActive) begin
				shownR[count] = int'(r);
				shownG[count] = int'(g);
				shownB[count] = int'(b);
				count++;
			end else begin
				// blanking is black
				check("r outside active video", r, 0);
				check("g outside active video", g, 0);
				check("b outside active video", b, 0);
			end
		end
		if (count < numPix) begin
			failNote("frame capture timed out before a full image was seen");
		end
	endtask

	task automatic comparePicture(kernelT kern);
		int want;
		for (int a = 0; a < numPix; a++) begin
			want = expectedPixel(kern, a % `IMG_W, a / `IMG_W);
			check($sformatf("r at pixel %0d", a), shownR[a], want);
			check($sformatf("g at pixel %0d", a), shownG[a], want);
			check($sformatf("b at pixel %0d", a), shownB[a], want);
		end
	endtask

	// one full frame between two vsync falls
	task automatic checkRaster();
		int waited;
		int falls;
		int syncPulses;
		int lines;
		int lineActive;
		logic lastVsync;
		logic lastHsync;
		logic lastActive;
		waited = 0;
		falls = 0;
		syncPulses = 0;
		lines = 0;
		lineActive = 0;
		lastVsync = vsync;
		lastHsync = hsync;
		lastActive = videoActive;
		while (falls < 2 && waited < frameLimit) begin
			@(negedge CLK);
			waited++;
			if (lastVsync && !vsync) begin
				falls++;
			end
			if (falls == 1) begin
				if (lastHsync && !hsync) begin
					syncPulses++;
				end
				if (videoActive) begin
					lineActive++;
				end
				if (lastActive && !videoActive) begin
					check("active clocks per line", lineActive, `IMG_W);
					lines++;
					lineActive = 0;
				end
			end
			lastVsync = vsync;
			lastHsync = hsync;
			lastActive = videoActive;
		end
		if (falls < 2) begin
			failNote("two vsync falls not seen within the timeout");
		end
		check("hsync pulses per frame", syncPulses, `V_TOTAL);
		check("active lines per frame", lines, `IMG_H);
	endtask

	initial begin
		void'($urandom(32'h775c));
		reset = 1'b1;
		kernel1 = 1'b0;
		kernel2 = 1'b0;
		kernel3 = 1'b0;
		identity = 1'b0;
		start = 1'b0;
		loadValid = 1'b0;
		loadAddr = '0;
		loadPixel = '0;
		repeat (4) @(posedge CLK);
		#2;
		reset = 1'b0;

		loadImage(1'b0);
		runPass(1'b0);
		captureFrame();
		comparePicture(kernIdentity);
		endTest("identity by default");

		pulseButtons(1'b1, 1'b0, 1'b0, 1'b0);
		runPass(1'b0);
		captureFrame();
		comparePicture(kernBlur);
		endTest("blur");

		// new image with black and white pixels
		loadImage(1'b1);
		pulseButtons(1'b0, 1'b1, 1'b0, 1'b0);
		runPass(1'b0);
		captureFrame();
		comparePicture(kernSharpen);
		pulseButtons(1'b0, 1'b0, 1'b1, 1'b0);
		runPass(1'b0);
		captureFrame();
		comparePicture(kernEdge);
		endTest("sharpen and edge with clamping");

		pulseButtons(1'b1, 1'b0, 1'b1, 1'b0);
		runPass(1'b0);
		captureFrame();
		comparePicture(kernBlur);
		pulseButtons(1'b0, 1'b1, 1'b0, 1'b1);
		runPass(1'b0);
		captureFrame();
		comparePicture(kernSharpen);
		endTest("button priority");

		// kernel3 pressed mid-pass applies to the next pass only
		pulseButtons(1'b0, 1'b1, 1'b0, 1'b0);
		runPass(1'b1);
		captureFrame();
		comparePicture(kernSharpen);
		runPass(1'b0);
		captureFrame();
		comparePicture(kernEdge);
		endTest("kernel latched per pass");

		checkRaster();
		endTest("raster timing");

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end
endmodule

// File: build.f
+incdir+design
design/filterPkg.sv
design/filterDecode.sv
design/imageMemory.sv
design/filterExecute.sv
design/filterResult.sv
design/scanOut.sv
design/filterTop.sv
sim/filterTb.sv

// File: run.sh
#!/bin/sh
# compile the filter testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module filterTb -o filterSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/filterSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1
